/* tb.f */
verilog/cpu_pkg.sv
verilog/cpu_alu.sv
verilog/cpu_regfile.sv
verilog/cpu_decoder.sv
verilog/cpu_bus_master.sv
verilog/cpu_control.sv
verilog/cpu_top.sv
bench/tb_clock.sv
bench/cpu_sva.sv
bench/tb_cpu.sv

/* Makefile */
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module tb_cpu -f tb.f

sim:
	verilator --binary --timing --assert -j 0 --top-module tb_cpu -Mdir obj_dir -f tb.f
	./obj_dir/Vtb_cpu | tee sim.log
	@if grep -q "STATUS: FAIL" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" sim.log || (echo "simulation ended early"; exit 1)

clean:
	rm -rf obj_dir sim.log

/* bench/tb_cpu.sv */
`timescale 1ns/1ns

module tb_cpu;

   localparam cpu_pkg::word_t reset_vec = 32'h0000_0100;
   localparam int period_ns = 40;
   // 64 instructions at 12 cycles each per program run
   localparam int run_cycles = 64 * 12;
   // reset vector run, four programs, four programs again with random ack
   localparam int runs = 9;

   logic clk;
   logic reset;
   logic ack_i;
   cpu_pkg::word_t dat_i;
   cpu_pkg::wb_m2s_t wb_o;

   // 8 KiB word memory, byte address bits 12:2
   logic [31:0] mem [2048];
   logic [31:0] prog_addr;
   logic [31:0] exp_addr [$];
   logic [31:0] exp_val [$];
   logic [31:0] lcg_state;
   logic [1:0] wait_left;
   logic active;
   logic random_ack;
   string delay_tag;
   string cur_test;
   int errors;
   int timeouts;

   tb_clock #(.period_ns(period_ns)) clock_i (.clk_o(clk));

   cpu_top #(.reset_vector_p(reset_vec)) dut_i (
      .clk(clk), .reset(reset), .ack_i(ack_i), .dat_i(dat_i), .wb_o(wb_o)
   );

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // fill word depends on the whole byte address
   function automatic logic [31:0] fill_word(input int i);
      logic [31:0] a;
      a = i * 4;
      return a ^ {a[15:0], a[31:16]} ^ 32'h6d3a_0000;
   endfunction

   // instruction encoders, fields as in the RV32I formats
   function automatic logic [31:0] r_type(input int f7, input int rs2, input int rs1,
                                          input int f3, input int rd);
      return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
   endfunction

   function automatic logic [31:0] i_type(input int imm, input int rs1, input int f3,
                                          input int rd, input int op);
      return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] s_type(input int imm, input int rs2, input int rs1);
      return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
   endfunction

   function automatic logic [31:0] b_type(input int imm, input int rs2, input int rs1,
                                          input int f3);
      return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
   endfunction

   function automatic logic [31:0] u_type(input int imm20, input int rd, input int op);
      return {imm20[19:0], rd[4:0], op[6:0]};
   endfunction

   function automatic logic [31:0] j_type(input int imm, input int rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6f};
   endfunction

   // RV32I branch conditions by funct3
   function automatic logic branch_rule(input int f3, input logic [31:0] a,
                                        input logic [31:0] b);
      case (f3)
         0: return a == b;
         1: return a != b;
         4: return $signed(a) < $signed(b);
         5: return $signed(a) >= $signed(b);
         6: return a < b;
         default: return a >= b;
      endcase
   endfunction

   // memory model, answers after 1 or 0..3 wait cycles
   always @(posedge clk) begin
      logic [31:0] rnd;
      #2;
      if (ack_i) begin
         ack_i = 1'b0;
         active = 1'b0;
      end else if (wb_o.cyc && wb_o.stb) begin
         if (!active) begin
            active = 1'b1;
            rnd = lcg_next();
            wait_left = random_ack ? rnd[17:16] : 2'd1;
            // every access is a full word
            assert (wb_o.sel == 4'b1111) else begin
               errors++;
               $display("[FAIL] %s: byte select expected %b actual %b",
                        cur_test, 4'b1111, wb_o.sel);
            end
         end
         if (wait_left == 2'd0) begin
            ack_i = 1'b1;
            if (wb_o.we) begin
               mem[wb_o.adr[12:2]] = wb_o.dat;
            end else begin
               dat_i = mem[wb_o.adr[12:2]];
            end
         end else begin
            wait_left = wait_left - 2'd1;
         end
      end
   end

   task automatic clear_memory();
      for (int i = 0; i < 2048; i++) begin
         mem[i] = fill_word(i);
      end
      exp_addr.delete();
      exp_val.delete();
      prog_addr = reset_vec;
   endtask

   task automatic emit(input logic [31:0] w);
      mem[prog_addr[12:2]] = w;
      prog_addr = prog_addr + 32'd4;
   endtask

   task automatic expect_word(input logic [31:0] addr, input logic [31:0] val);
      exp_addr.push_back(addr);
      exp_val.push_back(val);
   endtask

   task automatic apply_reset();
      @(posedge clk);
      #2 reset = 1'b1;
      repeat (16) @(posedge clk);
      #2 reset = 1'b0;
   endtask

   task automatic wait_halt(input string name);
      int cnt;
      cnt = 0;
      while (dut_i.control_i.state != cpu_pkg::st_halt && cnt < run_cycles) begin
         @(negedge clk);
         cnt++;
      end
      if (dut_i.control_i.state != cpu_pkg::st_halt) begin
         timeouts++;
         $display("%s: core did not halt within %0d cycles", name, run_cycles);
      end
      // a halted core stays off the bus
      repeat (10) begin
         @(negedge clk);
         assert (!wb_o.cyc) else begin
            errors++;
            $display("%s: bus cycle started after halt", name);
         end
      end
   endtask

   task automatic check_memory(input string name);
      logic [31:0] got;
      foreach (exp_addr[k]) begin
         got = mem[exp_addr[k][12:2]];
         assert (got == exp_val[k]) else begin
            errors++;
            $display("[FAIL] %s: word %h expected %h actual %h",
                     name, exp_addr[k], exp_val[k], got);
         end
      end
   endtask

   task automatic run_program(input string name);
      // illegal word parks the core
      emit(32'h0000_0000);
      cur_test = name;
      apply_reset();
      wait_halt(name);
      check_memory(name);
   endtask

   task automatic test_reset_vector();
      int cnt;
      clear_memory();
      emit(32'h0000_0000);
      cur_test = "reset vector";
      apply_reset();
      cnt = 0;
      while (!wb_o.cyc && cnt < run_cycles) begin
         @(negedge clk);
         cnt++;
      end
      assert (wb_o.cyc && !wb_o.we && wb_o.adr == reset_vec) else begin
         errors++;
         $display("[FAIL] reset vector: expected read at %h actual cyc %b we %b adr %h",
                  reset_vec, wb_o.cyc, wb_o.we, wb_o.adr);
      end
      wait_halt("reset vector");
   endtask

   task automatic test_alu_ops();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] alu_exp [14];
      a = 32'h8765_4321;
      b = 32'hffff_fff9;
      alu_exp[0] = 32'h0;
      alu_exp[1] = a;
      alu_exp[2] = b;
      alu_exp[3] = 32'd5;
      alu_exp[4] = a + b;
      alu_exp[5] = a - b;
      alu_exp[6] = a ^ b;
      alu_exp[7] = a | b;
      alu_exp[8] = a & b;
      alu_exp[9] = a << 5;
      alu_exp[10] = a >> 5;
      // sign bit copied into the five vacated bits
      alu_exp[11] = {{5{a[31]}}, a[31:5]};
      // -7 is below 5 when signed
      alu_exp[12] = 32'd1;
      // 0xfffffff9 is above 5 when unsigned
      alu_exp[13] = 32'd0;
      clear_memory();
      emit(u_type(1, 20, 'h37));
      emit(u_type('h87654, 1, 'h37));
      emit(i_type('h321, 1, 0, 1, 'h13));
      emit(i_type(-7, 0, 0, 2, 'h13));
      emit(i_type(5, 0, 0, 3, 'h13));
      emit(r_type(0, 2, 1, 0, 4));
      emit(r_type('h20, 2, 1, 0, 5));
      emit(r_type(0, 2, 1, 4, 6));
      emit(r_type(0, 2, 1, 6, 7));
      emit(r_type(0, 2, 1, 7, 8));
      emit(r_type(0, 3, 1, 1, 9));
      emit(r_type(0, 3, 1, 5, 10));
      emit(r_type('h20, 3, 1, 5, 11));
      emit(r_type(0, 3, 2, 2, 12));
      emit(r_type(0, 3, 2, 3, 13));
      // x0 ignores the write
      emit(i_type('h55, 0, 0, 0, 'h13));
      for (int r = 0; r < 14; r++) begin
         emit(s_type(4 * r, r, 20));
         expect_word(32'h1000 + 32'(4 * r), alu_exp[r]);
      end
      run_program({delay_tag, "alu ops"});
   endtask

   task automatic test_load_store();
      clear_memory();
      mem[('h1040) >> 2] = 32'hcafe_f00d;
      mem[('h1044) >> 2] = 32'h1234_5678;
      mem[('h10fc) >> 2] = 32'h0bad_beef;
      emit(u_type(1, 20, 'h37));
      emit(i_type('h100, 20, 0, 21, 'h13));
      emit(i_type('h300, 20, 0, 22, 'h13));
      emit(i_type('h40, 20, 2, 1, 'h03));
      emit(i_type('h44, 20, 2, 2, 'h03));
      // negative offset from base 0x1100
      emit(i_type(-4, 21, 2, 3, 'h03));
      emit(s_type('h200, 1, 20));
      emit(s_type('h204, 2, 20));
      emit(s_type(-8, 3, 21));
      emit(s_type(-'hf8, 1, 22));
      expect_word(32'h1200, 32'hcafe_f00d);
      expect_word(32'h1204, 32'h1234_5678);
      expect_word(32'h10f8, 32'h0bad_beef);
      expect_word(32'h1208, 32'hcafe_f00d);
      run_program({delay_tag, "load store"});
   endtask

   task automatic test_branches();
      int f3s [12];
      int rs1s [12];
      int rs2s [12];
      logic [31:0] regv [4];
      logic taken;
      f3s = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
      rs1s = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
      rs2s = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
      regv = '{32'h0, 32'hffff_ffff, 32'h1, 32'h1};
      clear_memory();
      emit(u_type(1, 20, 'h37));
      emit(i_type(-1, 0, 0, 1, 'h13));
      emit(i_type(1, 0, 0, 2, 'h13));
      emit(i_type(1, 0, 0, 3, 'h13));
      emit(i_type('h111, 0, 0, 5, 'h13));
      emit(i_type('h222, 0, 0, 6, 'h13));
      // each slot gets 0x111 on fall through, 0x222 when taken
      for (int k = 0; k < 12; k++) begin
         emit(b_type(12, rs2s[k], rs1s[k], f3s[k]));
         emit(s_type(4 * k, 5, 20));
         emit(j_type(8, 0));
         emit(s_type(4 * k, 6, 20));
         taken = branch_rule(f3s[k], regv[rs1s[k]], regv[rs2s[k]]);
         expect_word(32'h1000 + 32'(4 * k), taken ? 32'h222 : 32'h111);
      end
      run_program({delay_tag, "branches"});
   endtask

   task automatic test_jumps();
      logic [31:0] p_jal;
      logic [31:0] p_auipc;
      logic [31:0] p_jalr;
      clear_memory();
      emit(u_type(1, 20, 'h37));
      emit(u_type('hbad00, 7, 'h37));
      p_jal = prog_addr;
      emit(j_type(12, 1));
      // jump shadows store to their own word
      emit(s_type(12, 7, 20));
      emit(s_type(12, 7, 20));
      emit(s_type(0, 1, 20));
      p_auipc = prog_addr;
      emit(u_type(1, 2, 'h17));
      emit(s_type(4, 2, 20));
      // x3 points two words past the jalr
      emit(u_type(0, 3, 'h17));
      emit(i_type(16, 3, 0, 3, 'h13));
      p_jalr = prog_addr;
      emit(i_type(0, 3, 0, 4, 'h67));
      emit(s_type(12, 7, 20));
      emit(s_type(8, 4, 20));
      expect_word(32'h1000, p_jal + 32'd4);
      expect_word(32'h1004, p_auipc + 32'h1000);
      expect_word(32'h1008, p_jalr + 32'd4);
      // skipped words never run, so the fill stays
      expect_word(32'h100c, fill_word(32'h100c >> 2));
      run_program({delay_tag, "jumps"});
   endtask

   task automatic test_random_delay();
      random_ack = 1'b1;
      delay_tag = "random ack ";
      test_alu_ops();
      test_load_store();
      test_branches();
      test_jumps();
      random_ack = 1'b0;
      delay_tag = "";
   endtask

   initial begin
      reset = 1'b1;
      ack_i = 1'b0;
      dat_i = '0;
      active = 1'b0;
      wait_left = 2'd0;
      random_ack = 1'b0;
      delay_tag = "";
      cur_test = "";
      lcg_state = 32'h0736eee6;
      errors = 0;
      timeouts = 0;
      test_reset_vector();
      test_alu_ops();
      test_load_store();
      test_branches();
      test_jumps();
      test_random_delay();
      $display("check errors: %0d, timeouts: %0d, bus assertion failures: %0d",
               errors, timeouts, dut_i.bus_master_i.sva_i.fail_count);
      if (errors == 0 && timeouts == 0 && dut_i.bus_master_i.sva_i.fail_count == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

   // whole run bound, all program runs back to back
   initial begin
      #(runs * run_cycles * period_ns);
      $display("watchdog expired after %0d program runs worth of cycles", runs);
      $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* bench/cpu_sva.sv */
`timescale 1ns/1ns

module cpu_sva (
   input logic             clk,
   input logic             reset,
   input logic             ack_i,
   input cpu_pkg::wb_m2s_t wb_o
);

   // read by the testbench at the end of the run
   int unsigned fail_count = 0;

   // stb never without cyc
   stb_needs_cyc: assert property (@(posedge clk) disable iff (reset)
      wb_o.stb |-> wb_o.cyc)
      else begin
         fail_count++;
         $error("stb high while cyc is low");
      end

   // request held steady until the slave acks
   held_until_ack: assert property (@(posedge clk) disable iff (reset)
      (wb_o.stb && !ack_i) |=> (wb_o.stb && $stable(wb_o.adr)
                                && $stable(wb_o.we) && $stable(wb_o.dat)))
      else begin
         fail_count++;
         $error("bus request changed before ack");
      end

   // no cycle right out of reset
   idle_after_reset: assert property (@(posedge clk) reset |=> !wb_o.cyc)
      else begin
         fail_count++;
         $error("cyc high after reset");
      end

endmodule

bind cpu_bus_master cpu_sva sva_i (
   .clk(clk), .reset(reset), .ack_i(ack_i), .wb_o(wb_o)
);

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock #(
   parameter int period_ns = 40
) (
   output logic clk_o
);

   initial clk_o = 1'b0;

   // free running, half period per phase
   always #(period_ns / 2) clk_o = ~clk_o;

endmodule

/* verilog/cpu_top.sv */
`timescale 1ns/1ns

module cpu_top #(
   parameter cpu_pkg::word_t reset_vector_p = '0
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             ack_i,
   input  cpu_pkg::word_t   dat_i,
   output cpu_pkg::wb_m2s_t wb_o
);

   cpu_pkg::dec_ctrl_t dec_ctrl;
   cpu_pkg::instr_u instr;
   cpu_pkg::word_t regval1;
   cpu_pkg::word_t regval2;
   cpu_pkg::reg_idx_t rf_rd;
   cpu_pkg::word_t rf_wdata;
   cpu_pkg::alu_op_e alu_op;
   cpu_pkg::word_t op_a;
   cpu_pkg::word_t op_b;
   cpu_pkg::word_t alu_res;
   cpu_pkg::bus_req_t bus_req;
   cpu_pkg::word_t bus_rdata;
   logic dec_en;
   logic rf_we;
   logic lt;
   logic ltu;
   logic eq;
   logic bus_busy;

   // sequencing, pc and operand muxes
   cpu_control #(
      .reset_vector_p(reset_vector_p)
   ) control_i (
      .clk(clk), .reset(reset),
      .dec_i(dec_ctrl), .dec_en_o(dec_en), .instr_o(instr),
      .regval1_i(regval1), .regval2_i(regval2),
      .rf_we_o(rf_we), .rf_rd_o(rf_rd), .rf_wdata_o(rf_wdata),
      .alu_op_o(alu_op), .op_a_o(op_a), .op_b_o(op_b),
      .alu_res_i(alu_res), .lt_i(lt), .ltu_i(ltu), .eq_i(eq),
      .req_o(bus_req), .busy_i(bus_busy), .rdata_i(bus_rdata)
   );

   cpu_decoder decoder_i (
      .clk(clk), .en_i(dec_en), .instr_i(instr), .ctrl_o(dec_ctrl)
   );

   // register indices straight from the decoder
   cpu_regfile regfile_i (
      .clk(clk), .we_i(rf_we), .rd_i(rf_rd),
      .rs1_i(dec_ctrl.rs1), .rs2_i(dec_ctrl.rs2), .wdata_i(rf_wdata),
      .rdata1_o(regval1), .rdata2_o(regval2)
   );

   cpu_alu alu_i (
      .clk(clk), .reset(reset), .op_i(alu_op), .a_i(op_a), .b_i(op_b),
      .res_o(alu_res), .lt_o(lt), .ltu_o(ltu), .eq_o(eq)
   );

   // wishbone side
   cpu_bus_master bus_master_i (
      .clk(clk), .reset(reset), .req_i(bus_req),
      .busy_o(bus_busy), .rdata_o(bus_rdata),
      .ack_i(ack_i), .dat_i(dat_i), .wb_o(wb_o)
   );

endmodule

/* verilog/cpu_control.sv */
`timescale 1ns/1ns

module cpu_control #(
   parameter cpu_pkg::word_t reset_vector_p = '0
) (
   input  logic               clk,
   input  logic               reset,
   input  cpu_pkg::dec_ctrl_t dec_i,
   output logic               dec_en_o,
   output cpu_pkg::instr_u    instr_o,
   input  cpu_pkg::word_t     regval1_i,
   input  cpu_pkg::word_t     regval2_i,
   output logic               rf_we_o,
   output cpu_pkg::reg_idx_t  rf_rd_o,
   output cpu_pkg::word_t     rf_wdata_o,
   output cpu_pkg::alu_op_e   alu_op_o,
   output cpu_pkg::word_t     op_a_o,
   output cpu_pkg::word_t     op_b_o,
   input  cpu_pkg::word_t     alu_res_i,
   input  logic               lt_i,
   input  logic               ltu_i,
   input  logic               eq_i,
   output cpu_pkg::bus_req_t  req_o,
   input  logic               busy_i,
   input  cpu_pkg::word_t     rdata_i
);

   cpu_pkg::state_e state;
   cpu_pkg::state_e state_nxt;
   cpu_pkg::word_t pc;
   cpu_pkg::word_t pc_nxt;
   cpu_pkg::word_t link;
   cpu_pkg::instr_u instr;
   cpu_pkg::s1_sel_e s1_sel;
   cpu_pkg::s2_sel_e s2_sel;
   logic taken;
   logic [5:0] flags;

   always_comb begin
      state_nxt = state;
      case (state)
         cpu_pkg::st_reset:      state_nxt = cpu_pkg::st_fetch;
         cpu_pkg::st_fetch:      state_nxt = cpu_pkg::st_fetch_wait;
         cpu_pkg::st_fetch_wait: if (!busy_i) state_nxt = cpu_pkg::st_decode;
         cpu_pkg::st_decode:     state_nxt = cpu_pkg::st_exec;
         cpu_pkg::st_exec: begin
            case (dec_i.exec_kind)
               cpu_pkg::to_load,
               cpu_pkg::to_store:  state_nxt = cpu_pkg::st_mem;
               cpu_pkg::to_branch: state_nxt = cpu_pkg::st_branch;
               cpu_pkg::to_fetch,
               cpu_pkg::to_jump:   state_nxt = cpu_pkg::st_writeback;
               default:            state_nxt = cpu_pkg::st_halt;
            endcase
         end
         cpu_pkg::st_mem:        state_nxt = cpu_pkg::st_mem_wait;
         cpu_pkg::st_mem_wait:   if (!busy_i) state_nxt = cpu_pkg::st_writeback;
         cpu_pkg::st_branch:     state_nxt = cpu_pkg::st_writeback;
         cpu_pkg::st_writeback:  state_nxt = cpu_pkg::st_fetch;
         default:                state_nxt = cpu_pkg::st_halt;
      endcase
   end

   // next pc, taken only at the end of writeback
   always_comb begin
      case (dec_i.exec_kind)
         cpu_pkg::to_jump:   pc_nxt = {alu_res_i[31:1], 1'b0};
         cpu_pkg::to_branch: pc_nxt = taken ? alu_res_i : link;
         default:            pc_nxt = link;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= cpu_pkg::st_reset;
         pc <= reset_vector_p;
      end else begin
         state <= state_nxt;
         if (state == cpu_pkg::st_writeback) begin
            pc <= pc_nxt;
         end
      end
   end

   // ne/eq etc in the same order as the decoder mask
   assign flags = {!ltu_i, ltu_i, !lt_i, lt_i, !eq_i, eq_i};

   always_ff @(posedge clk) begin
      if (state == cpu_pkg::st_fetch_wait && !busy_i) begin
         instr <= rdata_i;
      end
      // alu still holds pc + 4 from the fetch wait
      if (state == cpu_pkg::st_decode) begin
         link <= alu_res_i;
      end
      // flags are from the compare in exec
      if (state == cpu_pkg::st_branch) begin
         taken <= |(dec_i.branch_mask & flags);
      end
   end

   assign instr_o = instr;
   assign dec_en_o = (state == cpu_pkg::st_decode);

   // alu operands, idle cycles compute pc + 4 or the branch target
   always_comb begin
      s1_sel = dec_i.s1_sel;
      s2_sel = dec_i.s2_sel;
      alu_op_o = dec_i.alu_op;
      if (state == cpu_pkg::st_fetch_wait) begin
         s1_sel = cpu_pkg::s1_pc;
         s2_sel = cpu_pkg::s2_instlen;
         alu_op_o = cpu_pkg::alu_add;
      end else if (state == cpu_pkg::st_branch) begin
         s1_sel = cpu_pkg::s1_pc;
         s2_sel = cpu_pkg::s2_imm;
         alu_op_o = cpu_pkg::alu_add;
      end
   end

   assign op_a_o = (s1_sel == cpu_pkg::s1_pc) ? pc : regval1_i;

   always_comb begin
      case (s2_sel)
         cpu_pkg::s2_regval2: op_b_o = regval2_i;
         cpu_pkg::s2_imm:     op_b_o = dec_i.imm;
         default:             op_b_o = cpu_pkg::inst_len;
      endcase
   end

   // fetch from pc, data accesses at the address from exec
   assign req_o.en = (state == cpu_pkg::st_fetch) || (state == cpu_pkg::st_mem);
   assign req_o.we = (state == cpu_pkg::st_mem) && (dec_i.exec_kind == cpu_pkg::to_store);
   assign req_o.addr = (state == cpu_pkg::st_fetch) ? pc : alu_res_i;
   assign req_o.wdata = regval2_i;

   assign rf_we_o = (state == cpu_pkg::st_writeback) && (dec_i.wb_sel != cpu_pkg::wb_none);
   assign rf_rd_o = dec_i.rd;

   always_comb begin
      case (dec_i.wb_sel)
         cpu_pkg::wb_bus: rf_wdata_o = rdata_i;
         cpu_pkg::wb_imm: rf_wdata_o = dec_i.imm;
         // jumps write the link, the alu holds their target
         default: rf_wdata_o = (dec_i.exec_kind == cpu_pkg::to_jump) ? link : alu_res_i;
      endcase
   end

endmodule

/* verilog/cpu_bus_master.sv */
`timescale 1ns/1ns

module cpu_bus_master (
   input  logic              clk,
   input  logic              reset,
   input  cpu_pkg::bus_req_t req_i,
   output logic              busy_o,
   output cpu_pkg::word_t    rdata_o,
   input  logic              ack_i,
   input  cpu_pkg::word_t    dat_i,
   output cpu_pkg::wb_m2s_t  wb_o
);

   logic cyc;
   logic we;
   logic start;
   cpu_pkg::word_t adr;
   cpu_pkg::word_t dat;

   // new request only while idle
   assign start = req_i.en && !cyc;

   always_ff @(posedge clk) begin
      if (reset) begin
         cyc <= 1'b0;
         we <= 1'b0;
      end else if (start) begin
         cyc <= 1'b1;
         we <= req_i.we;
      end else if (cyc && ack_i) begin
         // drop the cycle right after ack
         cyc <= 1'b0;
         we <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (start) begin
         adr <= {req_i.addr[31:2], 2'b00};
         dat <= req_i.wdata;
      end
      if (cyc && ack_i && !we) begin
         rdata_o <= dat_i;
      end
   end

   // busy ends the edge after ack
   assign busy_o = cyc;

   // single word cycles, stb follows cyc
   assign wb_o.cyc = cyc;
   assign wb_o.stb = cyc;
   assign wb_o.we = we;
   assign wb_o.adr = adr;
   assign wb_o.dat = dat;
   assign wb_o.sel = 4'b1111;

endmodule

/* verilog/cpu_decoder.sv */
`timescale 1ns/1ns

module cpu_decoder (
   input  logic               clk,
   input  logic               en_i,
   input  cpu_pkg::instr_u    instr_i,
   output cpu_pkg::dec_ctrl_t ctrl_o
);

   cpu_pkg::dec_ctrl_t ctrl_c;
   cpu_pkg::alu_op_e arith_op;
   cpu_pkg::word_t imm_i;
   cpu_pkg::word_t imm_s;
   cpu_pkg::word_t imm_b;
   cpu_pkg::word_t imm_u;
   cpu_pkg::word_t imm_j;
   logic alt;
   logic is_op;

   // bit 30 selects sub and sra
   assign alt = instr_i.r.funct7[5];
   assign is_op = (instr_i.r.opcode == cpu_pkg::opc_op);

   // sign extended immediates per format
   assign imm_i = {{20{instr_i.i.imm12[11]}}, instr_i.i.imm12};
   assign imm_s = {{20{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi, instr_i.s.imm_lo};
   assign imm_b = {{19{instr_i.s.imm_hi[6]}}, instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],
                   instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
   assign imm_u = {instr_i.u.imm20, 12'b0};
   assign imm_j = {{11{instr_i.u.imm20[19]}}, instr_i.u.imm20[19], instr_i.u.imm20[7:0],
                   instr_i.u.imm20[8], instr_i.u.imm20[18:9], 1'b0};

   // funct3 to alu op, sub only for register ops
   always_comb begin
      case (instr_i.r.funct3)
         3'd0:    arith_op = (is_op && alt) ? cpu_pkg::alu_sub : cpu_pkg::alu_add;
         3'd1:    arith_op = cpu_pkg::alu_sll;
         3'd2:    arith_op = cpu_pkg::alu_slt;
         3'd3:    arith_op = cpu_pkg::alu_sltu;
         3'd4:    arith_op = cpu_pkg::alu_xor;
         3'd5:    arith_op = alt ? cpu_pkg::alu_sra : cpu_pkg::alu_srl;
         3'd6:    arith_op = cpu_pkg::alu_or;
         default: arith_op = cpu_pkg::alu_and;
      endcase
   end

   always_comb begin
      ctrl_c = '0;
      ctrl_c.rs1 = instr_i.r.rs1;
      ctrl_c.rs2 = instr_i.r.rs2;
      ctrl_c.rd = instr_i.r.rd;
      ctrl_c.funct3 = instr_i.r.funct3;
      ctrl_c.imm = imm_i;
      ctrl_c.alu_op = cpu_pkg::alu_add;
      ctrl_c.s1_sel = cpu_pkg::s1_regval1;
      ctrl_c.s2_sel = cpu_pkg::s2_imm;
      ctrl_c.wb_sel = cpu_pkg::wb_none;
      // anything unknown parks the core
      ctrl_c.exec_kind = cpu_pkg::to_halt;
      // eq, ne, lt, ge, ltu, geu
      case (instr_i.r.funct3)
         3'b000:  ctrl_c.branch_mask = 6'b000001;
         3'b001:  ctrl_c.branch_mask = 6'b000010;
         3'b100:  ctrl_c.branch_mask = 6'b000100;
         3'b101:  ctrl_c.branch_mask = 6'b001000;
         3'b110:  ctrl_c.branch_mask = 6'b010000;
         3'b111:  ctrl_c.branch_mask = 6'b100000;
         default: ctrl_c.branch_mask = 6'b000000;
      endcase
      case (instr_i.r.opcode)
         cpu_pkg::opc_op: begin
            ctrl_c.alu_op = arith_op;
            ctrl_c.s2_sel = cpu_pkg::s2_regval2;
            ctrl_c.wb_sel = cpu_pkg::wb_alu;
            ctrl_c.exec_kind = cpu_pkg::to_fetch;
         end
         cpu_pkg::opc_op_imm: begin
            ctrl_c.alu_op = arith_op;
            ctrl_c.wb_sel = cpu_pkg::wb_alu;
            ctrl_c.exec_kind = cpu_pkg::to_fetch;
         end
         cpu_pkg::opc_load: begin
            ctrl_c.wb_sel = cpu_pkg::wb_bus;
            ctrl_c.exec_kind = cpu_pkg::to_load;
         end
         cpu_pkg::opc_store: begin
            ctrl_c.imm = imm_s;
            ctrl_c.exec_kind = cpu_pkg::to_store;
         end
         cpu_pkg::opc_branch: begin
            // exec compares rs1 with rs2
            ctrl_c.imm = imm_b;
            ctrl_c.s2_sel = cpu_pkg::s2_regval2;
            ctrl_c.exec_kind = cpu_pkg::to_branch;
         end
         cpu_pkg::opc_jal: begin
            ctrl_c.imm = imm_j;
            ctrl_c.s1_sel = cpu_pkg::s1_pc;
            ctrl_c.wb_sel = cpu_pkg::wb_alu;
            ctrl_c.exec_kind = cpu_pkg::to_jump;
         end
         cpu_pkg::opc_jalr: begin
            ctrl_c.wb_sel = cpu_pkg::wb_alu;
            ctrl_c.exec_kind = cpu_pkg::to_jump;
         end
         cpu_pkg::opc_lui: begin
            ctrl_c.imm = imm_u;
            ctrl_c.wb_sel = cpu_pkg::wb_imm;
            ctrl_c.exec_kind = cpu_pkg::to_fetch;
         end
         cpu_pkg::opc_auipc: begin
            ctrl_c.imm = imm_u;
            ctrl_c.s1_sel = cpu_pkg::s1_pc;
            ctrl_c.wb_sel = cpu_pkg::wb_alu;
            ctrl_c.exec_kind = cpu_pkg::to_fetch;
         end
         default: ctrl_c.wb_sel = cpu_pkg::wb_none;
      endcase
   end

   // valid the cycle after en
   always_ff @(posedge clk) begin
      if (en_i) begin
         ctrl_o <= ctrl_c;
      end
   end

endmodule

/* verilog/cpu_regfile.sv */
`timescale 1ns/1ns

module cpu_regfile (
   input  logic              clk,
   input  logic              we_i,
   input  cpu_pkg::reg_idx_t rd_i,
   input  cpu_pkg::reg_idx_t rs1_i,
   input  cpu_pkg::reg_idx_t rs2_i,
   input  cpu_pkg::word_t    wdata_i,
   output cpu_pkg::word_t    rdata1_o,
   output cpu_pkg::word_t    rdata2_o
);

   cpu_pkg::word_t regs [32];

   // x0 is never written
   always_ff @(posedge clk) begin
      if (we_i && rd_i != '0) begin
         regs[rd_i] <= wdata_i;
      end
   end

   // combinational read, old value during a write
   assign rdata1_o = (rs1_i == '0) ? '0 : regs[rs1_i];
   assign rdata2_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

/* verilog/cpu_alu.sv */
`timescale 1ns/1ns

module cpu_alu (
   input  logic             clk,
   input  logic             reset,
   input  cpu_pkg::alu_op_e op_i,
   input  cpu_pkg::word_t   a_i,
   input  cpu_pkg::word_t   b_i,
   output cpu_pkg::word_t   res_o,
   output logic             lt_o,
   output logic             ltu_o,
   output logic             eq_o
);

   cpu_pkg::word_t res_c;
   logic lt_c;
   logic ltu_c;
   logic [4:0] shamt;

   // shifts use the low five bits only
   assign shamt = b_i[4:0];
   assign lt_c = $signed(a_i) < $signed(b_i);
   assign ltu_c = a_i < b_i;

   always_comb begin
      case (op_i)
         cpu_pkg::alu_add:  res_c = a_i + b_i;
         cpu_pkg::alu_sub:  res_c = a_i - b_i;
         cpu_pkg::alu_sll:  res_c = a_i << shamt;
         cpu_pkg::alu_slt:  res_c = {31'b0, lt_c};
         cpu_pkg::alu_sltu: res_c = {31'b0, ltu_c};
         cpu_pkg::alu_xor:  res_c = a_i ^ b_i;
         cpu_pkg::alu_srl:  res_c = a_i >> shamt;
         // arithmetic shift keeps the sign
         cpu_pkg::alu_sra:  res_c = $signed(a_i) >>> shamt;
         cpu_pkg::alu_or:   res_c = a_i | b_i;
         cpu_pkg::alu_and:  res_c = a_i & b_i;
         default:           res_c = a_i + b_i;
      endcase
   end

   // result and flags one cycle after the operands
   always_ff @(posedge clk) begin
      if (reset) begin
         res_o <= '0;
         lt_o <= 1'b0;
         ltu_o <= 1'b0;
         eq_o <= 1'b0;
      end else begin
         res_o <= res_c;
         lt_o <= lt_c;
         ltu_o <= ltu_c;
         eq_o <= (a_i == b_i);
      end
   end

endmodule

/* verilog/cpu_pkg.sv */
package cpu_pkg;

   // data and address word
   typedef logic [31:0] word_t;
   // register index
   typedef logic [4:0] reg_idx_t;

   // every instruction is one word
   localparam word_t inst_len = 32'd4;

   // major opcodes the core executes
   typedef enum logic [6:0] {
      opc_op     = 7'b0110011,
      opc_op_imm = 7'b0010011,
      opc_load   = 7'b0000011,
      opc_store  = 7'b0100011,
      opc_branch = 7'b1100011,
      opc_jal    = 7'b1101111,
      opc_jalr   = 7'b1100111,
      opc_lui    = 7'b0110111,
      opc_auipc  = 7'b0010111
   } opcode_e;

   typedef enum logic [3:0] {
      alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
      alu_xor, alu_srl, alu_sra, alu_or, alu_and
   } alu_op_e;

   // control FSM
   typedef enum logic [3:0] {
      st_reset, st_fetch, st_fetch_wait, st_decode, st_exec,
      st_mem, st_mem_wait, st_branch, st_writeback, st_halt
   } state_e;

   // what follows the execute state
   typedef enum logic [2:0] {
      to_fetch, to_load, to_store, to_branch, to_jump, to_halt
   } exec_kind_e;

   typedef enum logic {s1_regval1, s1_pc} s1_sel_e;
   typedef enum logic [1:0] {s2_regval2, s2_imm, s2_instlen} s2_sel_e;
   typedef enum logic [1:0] {wb_alu, wb_bus, wb_imm, wb_none} wb_sel_e;

   // the four views of one fetched word
   typedef struct packed {
      logic [6:0] funct7;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      reg_idx_t   rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm12;
      reg_idx_t    rs1;
      logic [2:0]  funct3;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   // b-type immediate is built from this view as well
   typedef struct packed {
      logic [6:0] imm_hi;
      reg_idx_t   rs2;
      reg_idx_t   rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   // j-type immediate comes from imm20
   typedef struct packed {
      logic [19:0] imm20;
      reg_idx_t    rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      u_fmt_t u;
   } instr_u;

   // decoder output, registered
   typedef struct packed {
      reg_idx_t   rs1;
      reg_idx_t   rs2;
      reg_idx_t   rd;
      word_t      imm;
      alu_op_e    alu_op;
      s1_sel_e    s1_sel;
      s2_sel_e    s2_sel;
      wb_sel_e    wb_sel;
      exec_kind_e exec_kind;
      logic [5:0] branch_mask;
      logic [2:0] funct3;
   } dec_ctrl_t;

   // one word access, en is a single cycle pulse
   typedef struct packed {
      logic  en;
      logic  we;
      word_t addr;
      word_t wdata;
   } bus_req_t;

   // wishbone master outputs
   typedef struct packed {
      logic       cyc;
      logic       stb;
      logic       we;
      word_t      adr;
      word_t      dat;
      logic [3:0] sel;
   } wb_m2s_t;

endpackage
